// ==== Makefile ====
# Verilator build and run of the decode/execute slice testbench

VERILATOR ?= verilator
TOP       ?= tbDecodeExecute
FILELIST  ?= compile.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@grep -q "^TEST OK$$" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== compile.f ====
+incdir+rtl
rtl/isaPkg.sv
rtl/ctrlPkg.sv
rtl/control.sv
rtl/aluDecoder.sv
rtl/immExtend.sv
rtl/alu.sv
rtl/executeStage.sv
rtl/decodeExecuteTop.sv
testbench/tbDecodeExecute.sv

// ==== rtl/alu.sv ====
module alu import isaPkg::*, ctrlPkg::*; (
    input  wordT    srcA,
    input  wordT    srcB,
    input  aluCtrlT aluControl,
    output wordT    aluResult,
    output logic    flagE       // branch condition
);

    logic [4:0] shamt;  // low 5 bits only
    logic       isEq;
    logic       isLt;   // signed
    logic       isLtu;  // unsigned

    assign shamt = srcB[4:0];
    assign isEq  = (srcA == srcB);
    assign isLt  = ($signed(srcA) < $signed(srcB));
    assign isLtu = (srcA < srcB);

    always_comb begin
        aluResult = '0;   // compares leave the result at zero
        flagE     = 1'b0; // low unless a branch compare
        case (aluControl)
            ALU_ADD:   aluResult = srcA + srcB;
            ALU_SUB:   aluResult = srcA - srcB;
            ALU_AND:   aluResult = srcA & srcB;
            ALU_OR:    aluResult = srcA | srcB;
            ALU_XOR:   aluResult = srcA ^ srcB;
            ALU_SLL:   aluResult = srcA << shamt;
            ALU_SRL:   aluResult = srcA >> shamt;
            ALU_SRA:   aluResult = $signed(srcA) >>> shamt; // keeps the sign
            ALU_SLT:   aluResult = wordT'(isLt);
            ALU_SLTU:  aluResult = wordT'(isLtu);
            ALU_PASSB: aluResult = srcB;                    // lui
            ALU_BEQ:   flagE = isEq;
            ALU_BNE:   flagE = !isEq;
            ALU_BLT:   flagE = isLt;
            ALU_BGE:   flagE = !isLt;
            ALU_BLTU:  flagE = isLtu;
            ALU_BGEU:  flagE = !isLtu;
            default:   aluResult = srcA + srcB;
        endcase
    end

endmodule

// ==== rtl/aluDecoder.sv ====
module aluDecoder import isaPkg::*, ctrlPkg::*; (
    input  aluOpT   aluopD,
    input  funct3T  funct3,
    input  logic    funct7b5,   // instr[30]
    output aluCtrlT aluControl
);

    logic subSel; // sub only exists in r-type

    assign subSel = (aluopD == ALUOP_RTYPE) && funct7b5;

    always_comb begin
        case (aluopD)
            ALUOP_RTYPE, ALUOP_ITYPE: begin
                case (funct3)
                    3'b000:  aluControl = subSel ? ALU_SUB : ALU_ADD;
                    3'b001:  aluControl = ALU_SLL;
                    3'b010:  aluControl = ALU_SLT;
                    3'b011:  aluControl = ALU_SLTU;
                    3'b100:  aluControl = ALU_XOR;
                    3'b101:  aluControl = funct7b5 ? ALU_SRA : ALU_SRL; // srai too
                    3'b110:  aluControl = ALU_OR;
                    default: aluControl = ALU_AND;
                endcase
            end
            ALUOP_BRANCH: begin
                case (funct3)
                    3'b000:  aluControl = ALU_BEQ;
                    3'b001:  aluControl = ALU_BNE;
                    3'b100:  aluControl = ALU_BLT;
                    3'b101:  aluControl = ALU_BGE;
                    3'b110:  aluControl = ALU_BLTU;
                    3'b111:  aluControl = ALU_BGEU;
                    default: aluControl = ALU_ADD; // reserved, flag stays low
                endcase
            end
            ALUOP_LUI: aluControl = ALU_PASSB; // imm straight through
            // load, store, jumps and auipc all need an add
            ALUOP_LOAD,
            ALUOP_STORE,
            ALUOP_JUMP,
            ALUOP_AUIPC: aluControl = ALU_ADD;
            default:     aluControl = ALU_ADD;
        endcase
    end

endmodule

// ==== rtl/control.sv ====
`include "core_params.svh"

module control import isaPkg::*, ctrlPkg::*; (
    input  opcodeT    opcodeD,    // instr[6:0]
    input  logic      flagE,      // branch compare outcome from alu
    output logic      pcsrcD,
    output resultSrcT resultsrcD,
    output logic      memwriteD,
    output logic      alusrcD,
    output immSrcT    immsrcD,
    output logic      regwriteD,
    output aluOpT     aluopD,
    output logic      jalrD
);

    always_comb begin
        // instruction class for the alu decoder
        case (opcodeD)
            `OP_RTYPE:  aluopD = ALUOP_RTYPE;
            `OP_ITYPE:  aluopD = ALUOP_ITYPE;
            `OP_LOAD:   aluopD = ALUOP_LOAD;
            `OP_STORE:  aluopD = ALUOP_STORE;
            `OP_BRANCH: aluopD = ALUOP_BRANCH;
            `OP_JAL:    aluopD = ALUOP_JUMP;
            `OP_JALR:   aluopD = ALUOP_JUMP; // alu add gives rs1+imm
            `OP_LUI:    aluopD = ALUOP_LUI;
            `OP_AUIPC:  aluopD = ALUOP_AUIPC;
            default:    aluopD = ALUOP_RTYPE;
        endcase

        case (opcodeD)
            `OP_JALR: jalrD = 1'b1; // target base is rs1
            default:  jalrD = 1'b0;
        endcase

        case (opcodeD)
            `OP_RTYPE: resultsrcD = RES_ALU;
            `OP_ITYPE: resultsrcD = RES_ALU;
            `OP_LOAD:  resultsrcD = RES_LOAD;
            `OP_JAL:   resultsrcD = RES_PC4;  // link
            `OP_JALR:  resultsrcD = RES_PC4;
            `OP_AUIPC: resultsrcD = RES_PCIMM;
            default:   resultsrcD = RES_ALU;  // lui goes through passB
        endcase

        case (opcodeD)
            `OP_STORE: memwriteD = 1'b1;
            default:   memwriteD = 1'b0;
        endcase

        case (opcodeD)
            `OP_RTYPE:  alusrcD = 1'b0;
            `OP_ITYPE:  alusrcD = 1'b1;
            `OP_LOAD:   alusrcD = 1'b1; // address = rs1 + imm
            `OP_STORE:  alusrcD = 1'b1;
            `OP_BRANCH: alusrcD = 1'b0; // compares rs1 with rs2
            `OP_JAL:    alusrcD = 1'b1;
            `OP_JALR:   alusrcD = 1'b1;
            `OP_LUI:    alusrcD = 1'b1;
            `OP_AUIPC:  alusrcD = 1'b1;
            default:    alusrcD = 1'b0;
        endcase

        case (opcodeD)
            `OP_ITYPE:  immsrcD = IMM_I;
            `OP_LOAD:   immsrcD = IMM_I;
            `OP_JALR:   immsrcD = IMM_I;
            `OP_STORE:  immsrcD = IMM_S;
            `OP_BRANCH: immsrcD = IMM_B;
            `OP_LUI:    immsrcD = IMM_U;
            `OP_AUIPC:  immsrcD = IMM_U;
            `OP_JAL:    immsrcD = IMM_J;
            default:    immsrcD = IMM_I; // r-type has no immediate
        endcase

        case (opcodeD)
            `OP_RTYPE:  regwriteD = 1'b1;
            `OP_ITYPE:  regwriteD = 1'b1;
            `OP_LOAD:   regwriteD = 1'b1;
            `OP_STORE:  regwriteD = 1'b0; // no rd
            `OP_BRANCH: regwriteD = 1'b0; // no rd
            `OP_JAL:    regwriteD = 1'b1;
            `OP_JALR:   regwriteD = 1'b1;
            `OP_LUI:    regwriteD = 1'b1;
            `OP_AUIPC:  regwriteD = 1'b1;
            default:    regwriteD = 1'b0; // unknown opcode writes nothing
        endcase

        case (opcodeD)
            `OP_BRANCH: pcsrcD = flagE; // taken only if compare holds
            `OP_JAL:    pcsrcD = 1'b1;
            `OP_JALR:   pcsrcD = 1'b1;
            default:    pcsrcD = 1'b0;
        endcase
    end

endmodule

// ==== rtl/core_params.svh ====
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

`define DATA_WIDTH      32 // machine word
`define INSTR_WIDTH     32 // base isa only, no compressed
`define REG_ADDR_WIDTH  5  // x0..x31
`define OPCODE_WIDTH    7
`define FUNCT3_WIDTH    3

// major opcodes, bits 6:0 of the instruction
`define OP_RTYPE   7'b0110011 // add, sub, sll ...
`define OP_ITYPE   7'b0010011 // addi, slli ...
`define OP_LOAD    7'b0000011 // lb, lh, lw ...
`define OP_STORE   7'b0100011 // sb, sh, sw
`define OP_BRANCH  7'b1100011 // beq .. bgeu
`define OP_JAL     7'b1101111
`define OP_JALR    7'b1100111
`define OP_LUI     7'b0110111
`define OP_AUIPC   7'b0010111

`endif

// ==== rtl/ctrlPkg.sv ====
package ctrlPkg;

    typedef logic [2:0] aluOpT; // instruction class out of the main decoder
    localparam aluOpT ALUOP_RTYPE  = 3'b000;
    localparam aluOpT ALUOP_ITYPE  = 3'b001;
    localparam aluOpT ALUOP_LOAD   = 3'b010;
    localparam aluOpT ALUOP_STORE  = 3'b011;
    localparam aluOpT ALUOP_BRANCH = 3'b100;
    localparam aluOpT ALUOP_JUMP   = 3'b101; // jal and jalr share this
    localparam aluOpT ALUOP_LUI    = 3'b110;
    localparam aluOpT ALUOP_AUIPC  = 3'b111;

    typedef logic [2:0] immSrcT; // immediate format
    localparam immSrcT IMM_I = 3'b000;
    localparam immSrcT IMM_S = 3'b001;
    localparam immSrcT IMM_B = 3'b010;
    localparam immSrcT IMM_U = 3'b011;
    localparam immSrcT IMM_J = 3'b100;

    typedef logic [1:0] resultSrcT; // writeback source
    localparam resultSrcT RES_ALU   = 2'b00;
    localparam resultSrcT RES_LOAD  = 2'b01; // alu address passed on
    localparam resultSrcT RES_PC4   = 2'b10; // link value
    localparam resultSrcT RES_PCIMM = 2'b11; // auipc

    typedef enum logic [4:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU, ALU_PASSB,
        ALU_BEQ, ALU_BNE, ALU_BLT, ALU_BGE, ALU_BLTU, ALU_BGEU
    } aluCtrlT;

endpackage

// ==== rtl/decodeExecuteTop.sv ====
module decodeExecuteTop import isaPkg::*; (
    input  logic               clk,
    input  logic               reset,
    input  logic               instrValid,
    input  instrT              instr,
    input  wordT               pc,
    input  wordT               rs1Data,
    input  wordT               rs2Data,
    output logic               outValid,
    output logic               regWrite,
    output logic               memWrite,
    output ctrlPkg::resultSrcT resultSrc,
    output regAddrT            rdAddr,
    output wordT               result,
    output wordT               storeData,
    output wordT               pcNext,
    output logic               pcTaken
);

    opcodeT             opcode;
    funct3T             funct3;
    logic               funct7b5;
    regAddrT            rd;
    logic               flagE;      // alu back into control, same cycle
    logic               pcsrcD;
    ctrlPkg::resultSrcT resultsrcD;
    logic               memwriteD;
    logic               alusrcD;
    ctrlPkg::immSrcT    immsrcD;
    logic               regwriteD;
    ctrlPkg::aluOpT     aluopD;
    logic               jalrD;
    ctrlPkg::aluCtrlT   aluControl;
    wordT               immExt;
    wordT               srcB;       // muxed in the execute stage
    wordT               aluResult;

    assign opcode   = opcodeOf(instr);
    assign funct3   = funct3Of(instr);
    assign funct7b5 = funct7b5Of(instr);
    assign rd       = rdOf(instr);

    control uControl (
        .opcodeD(opcode), .flagE(flagE), .pcsrcD(pcsrcD), .resultsrcD(resultsrcD),
        .memwriteD(memwriteD), .alusrcD(alusrcD), .immsrcD(immsrcD),
        .regwriteD(regwriteD), .aluopD(aluopD), .jalrD(jalrD)
    );

    aluDecoder uAluDecoder (
        .aluopD(aluopD), .funct3(funct3), .funct7b5(funct7b5), .aluControl(aluControl)
    );

    immExtend uImmExtend (.instr(instr), .immsrcD(immsrcD), .immExt(immExt));

    alu uAlu (
        .srcA(rs1Data), .srcB(srcB), .aluControl(aluControl),
        .aluResult(aluResult), .flagE(flagE)
    );

    executeStage uExecute (
        .clk(clk), .reset(reset), .instrValid(instrValid), .pc(pc), .immExt(immExt),
        .rs1Data(rs1Data), .rs2Data(rs2Data), .aluResult(aluResult),
        .alusrcD(alusrcD), .pcsrcD(pcsrcD), .jalrD(jalrD), .resultsrcD(resultsrcD),
        .regwriteD(regwriteD), .memwriteD(memwriteD), .rd(rd), .srcB(srcB),
        .outValid(outValid), .regWrite(regWrite), .memWrite(memWrite),
        .resultSrc(resultSrc), .rdAddr(rdAddr), .result(result),
        .storeData(storeData), .pcNext(pcNext), .pcTaken(pcTaken)
    );

endmodule

// ==== rtl/executeStage.sv ====
module executeStage import isaPkg::*, ctrlPkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      instrValid,
    input  wordT      pc,
    input  wordT      immExt,
    input  wordT      rs1Data,
    input  wordT      rs2Data,
    input  wordT      aluResult,
    input  logic      alusrcD,
    input  logic      pcsrcD,
    input  logic      jalrD,
    input  resultSrcT resultsrcD,
    input  logic      regwriteD,
    input  logic      memwriteD,
    input  regAddrT   rd,
    output wordT      srcB,       // second alu operand
    output logic      outValid,
    output logic      regWrite,
    output logic      memWrite,
    output resultSrcT resultSrc,
    output regAddrT   rdAddr,
    output wordT      result,
    output wordT      storeData,
    output wordT      pcNext,
    output logic      pcTaken
);

    wordT pcPlus4;
    wordT pcPlusImm;    // branch, jal and auipc
    wordT jumpSum;      // jalr base
    wordT target;
    wordT resultNext;

    assign srcB      = alusrcD ? immExt : rs2Data;
    assign pcPlus4   = pc + wordT'(4);
    assign pcPlusImm = pc + immExt;
    assign jumpSum   = rs1Data + immExt;
    assign target    = jalrD ? (jumpSum & ~wordT'(1)) : pcPlusImm; // jalr clears bit 0

    always_comb begin
        case (resultsrcD)
            RES_ALU:   resultNext = aluResult;
            RES_LOAD:  resultNext = aluResult; // memory address
            RES_PC4:   resultNext = pcPlus4;
            RES_PCIMM: resultNext = pcPlusImm;
            default:   resultNext = aluResult;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            outValid <= 1'b0;
            regWrite <= 1'b0;
            memWrite <= 1'b0;
            pcTaken  <= 1'b0;
        end else begin
            outValid <= instrValid; // one cycle per issued instruction
            regWrite <= instrValid && regwriteD;
            memWrite <= instrValid && memwriteD;
            pcTaken  <= instrValid && pcsrcD;
        end
    end

    always_ff @(posedge clk) begin
        if (instrValid) begin // data holds when idle
            resultSrc <= resultsrcD;
            rdAddr    <= rd;
            result    <= resultNext;
            storeData <= rs2Data;
            pcNext    <= pcsrcD ? target : pcPlus4;
        end
    end

endmodule

// ==== rtl/immExtend.sv ====
module immExtend import isaPkg::*, ctrlPkg::*; (
    input  instrT  instr,
    input  immSrcT immsrcD,
    output wordT   immExt
);

    logic sign; // every format takes its sign from bit 31

    assign sign = instr[31];

    always_comb begin
        case (immsrcD)
            IMM_I: immExt = {{20{sign}}, instr[31:20]};
            IMM_S: immExt = {{20{sign}}, instr[31:25], instr[11:7]};
            IMM_B: immExt = {{19{sign}}, instr[31], instr[7],
                             instr[30:25], instr[11:8], 1'b0}; // halfword offset
            IMM_U: immExt = {instr[31:12], 12'b0};              // upper 20 bits
            IMM_J: immExt = {{11{sign}}, instr[31], instr[19:12],
                             instr[20], instr[30:21], 1'b0};
            default: immExt = {{20{sign}}, instr[31:20]};       // treat as i-type
        endcase
    end

endmodule

// ==== rtl/isaPkg.sv ====
package isaPkg;

`include "core_params.svh"

    typedef logic [`DATA_WIDTH-1:0]     wordT;    // data or address word
    typedef logic [`INSTR_WIDTH-1:0]    instrT;   // raw instruction
    typedef logic [`OPCODE_WIDTH-1:0]   opcodeT;  // bits 6:0
    typedef logic [`FUNCT3_WIDTH-1:0]   funct3T;  // bits 14:12
    typedef logic [`REG_ADDR_WIDTH-1:0] regAddrT; // register index

    // field extraction, same positions for every format that has the field
    function automatic opcodeT opcodeOf(input instrT instr);
        return instr[6:0];
    endfunction

    function automatic funct3T funct3Of(input instrT instr);
        return instr[14:12];
    endfunction

    function automatic regAddrT rdOf(input instrT instr);
        return instr[11:7];
    endfunction

    function automatic logic funct7b5Of(input instrT instr);
        return instr[30]; // sub / sra select
    endfunction

endpackage

// ==== testbench/tbDecodeExecute.sv ====
`include "core_params.svh"

module tbDecodeExecute import isaPkg::*, ctrlPkg::*;;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_INSTR = 40 + 36 + 12 + 36 + 16 + 60; // r, i, ld/st, br, jump/upper, mix
    localparam int NUM_MIX   = 60;

    typedef struct packed {
        logic      regWrite;
        logic      memWrite;
        resultSrcT resultSrc;
        regAddrT   rdAddr;
        wordT      result;
        wordT      storeData;
        wordT      pcNext;
        logic      pcTaken;
        int        due;       // negedge count at which outValid shows up
    } expectT;

    logic      clk;
    logic      reset;
    logic      instrValid;
    instrT     instr;
    wordT      pc;
    wordT      rs1Data;
    wordT      rs2Data;
    logic      outValid;
    logic      regWrite;
    logic      memWrite;
    resultSrcT resultSrc;
    regAddrT   rdAddr;
    wordT      result;
    wordT      storeData;
    wordT      pcNext;
    logic      pcTaken;

    expectT expQ[$];     // one entry per issued instruction
    int     negCount  = 0;
    int     checked   = 0;

    decodeExecuteTop UUT (
        .clk(clk), .reset(reset), .instrValid(instrValid), .instr(instr), .pc(pc),
        .rs1Data(rs1Data), .rs2Data(rs2Data), .outValid(outValid), .regWrite(regWrite),
        .memWrite(memWrite), .resultSrc(resultSrc), .rdAddr(rdAddr), .result(result),
        .storeData(storeData), .pcNext(pcNext), .pcTaken(pcTaken)
    );

    always #20 clk = ~clk; // 40 ns period

    function automatic wordT randWord();
        return $urandom();
    endfunction

    // integer ops of the isa, alt picks sub or sra
    function automatic wordT aluRef(input funct3T f3, input logic alt,
                                    input wordT a, input wordT b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return {31'b0, ($signed(a) < $signed(b))};
            3'b011:  return {31'b0, (a < b)};
            3'b100:  return a ^ b;
            3'b101:  return alt ? wordT'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branchRef(input funct3T f3, input wordT a, input wordT b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            default: return a >= b; // bgeu
        endcase
    endfunction

    function automatic expectT predict(input instrT i, input wordT p,
                                       input wordT a, input wordT b);
        expectT e;
        wordT   immI;
        wordT   immS;
        wordT   immB;
        wordT   immU;
        wordT   immJ;
        logic   alt;
        immI = {{20{i[31]}}, i[31:20]};
        immS = {{20{i[31]}}, i[31:25], i[11:7]};
        immB = {{20{i[31]}}, i[7], i[30:25], i[11:8], 1'b0};
        immU = {i[31:12], 12'b0};
        immJ = {{12{i[31]}}, i[19:12], i[20], i[30:21], 1'b0};
        alt  = i[30] && (i[14:12] == 3'b101 || (i[6:0] == `OP_RTYPE && i[14:12] == 3'b000));
        e           = '0;
        e.rdAddr    = i[11:7];
        e.storeData = b;          // always rs2
        e.resultSrc = RES_ALU;
        e.pcNext    = p + 32'd4;  // fall through
        e.regWrite  = (i[6:0] != `OP_STORE) && (i[6:0] != `OP_BRANCH);
        case (i[6:0])
            `OP_RTYPE: e.result = aluRef(i[14:12], alt, a, b);
            `OP_ITYPE: e.result = aluRef(i[14:12], alt, a, immI);
            `OP_LOAD: begin
                e.result    = a + immI; // address only
                e.resultSrc = RES_LOAD;
            end
            `OP_STORE: begin
                e.result   = a + immS;
                e.memWrite = 1'b1;
            end
            `OP_BRANCH: begin
                e.pcTaken = branchRef(i[14:12], a, b); // result stays zero
                if (e.pcTaken)
                    e.pcNext = p + immB;
            end
            `OP_JAL, `OP_JALR: begin
                e.result    = p + 32'd4; // link
                e.resultSrc = RES_PC4;
                e.pcTaken   = 1'b1;
                e.pcNext    = (i[6:0] == `OP_JAL) ? p + immJ : (a + immI) & 32'hFFFF_FFFE;
            end
            `OP_LUI:   e.result = immU;
            default: begin // auipc
                e.result    = p + immU;
                e.resultSrc = RES_PCIMM;
            end
        endcase
        return e;
    endfunction

    task automatic stopRun(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic checkWord(input string name, input wordT got, input wordT exp);
        if (got !== exp)
            stopRun($sformatf("FAIL t=%0t %s got %h expected %h", $time, name, got, exp));
    endtask

    task automatic checkBit(input string name, input logic got, input logic exp);
        if (got !== exp)
            stopRun($sformatf("FAIL t=%0t %s got %b expected %b", $time, name, got, exp));
    endtask

    task automatic checkResultSrc(input string name, input resultSrcT got, input resultSrcT exp);
        if (got !== exp)
            stopRun($sformatf("FAIL t=%0t %s got %0d expected %0d", $time, name, got, exp));
    endtask

    task automatic checkRegAddr(input string name, input regAddrT got, input regAddrT exp);
        if (got !== exp)
            stopRun($sformatf("FAIL t=%0t %s got %0d expected %0d", $time, name, got, exp));
    endtask

    task automatic issue(input instrT i, input wordT a, input wordT b);
        expectT e;
        wordT   p;
        p = randWord() & 32'hFFFF_FFFC; // word aligned pc
        @(posedge clk);
        instrValid <= 1'b1;
        instr      <= i;
        pc         <= p;
        rs1Data    <= a;
        rs2Data    <= b;
        e     = predict(i, p, a, b);
        e.due = negCount + 2; // sampled next edge, seen at the negedge after it
        expQ.push_back(e);
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            instrValid <= 1'b0;
            instr      <= randWord(); // garbage must stay gated
            rs1Data    <= randWord();
        end
    endtask

    // kind 0 r, 1 i, 2 load, 3 store, 4 branch, 5 jal, 6 jalr, 7 lui, 8 auipc
    task automatic issueOp(input int kind, input funct3T f3, input logic alt, input int mode);
        logic [31:0] r;
        wordT        a;
        wordT        b;
        instrT       i;
        r = randWord();
        a = randWord();
        b = randWord();
        case (kind)
            0: i = {1'b0, alt, 5'b0, r[24:15], f3, r[11:7], `OP_RTYPE};
            1: begin
                i = {r[31:15], f3, r[11:7], `OP_ITYPE};
                if (f3 == 3'b001 || f3 == 3'b101)
                    i[31:25] = {1'b0, alt, 5'b0}; // shift immediates
            end
            2: i = {r[31:15], 3'b010, r[11:7], `OP_LOAD};
            3: i = {r[31:15], 3'b010, r[11:7], `OP_STORE};
            4: i = {r[31:15], f3, r[11:7], `OP_BRANCH};
            5: i = {r[31:7], `OP_JAL};
            6: i = {r[31:15], 3'b000, r[11:7], `OP_JALR};
            7: i = {r[31:7], `OP_LUI};
            default: i = {r[31:7], `OP_AUIPC};
        endcase
        if (mode == 1)
            b = a; // equal operands
        else if (mode == 2) begin
            a = a | 32'h8000_0000; // signed and unsigned order disagree
            b = b & 32'h7FFF_FFFF;
        end
        issue(i, a, b);
    endtask

    always @(negedge clk) begin
        expectT e;
        negCount = negCount + 1;
        if (!reset) begin
            if (outValid === 1'b1) begin
                if (expQ.size() == 0)
                    stopRun("outValid went high with no instruction pending");
                else begin
                    e = expQ.pop_front();
                    if (e.due != negCount)
                        stopRun("outValid came outside its one-cycle slot");
                    checkBit("regWrite", regWrite, e.regWrite);
                    checkBit("memWrite", memWrite, e.memWrite);
                    checkBit("pcTaken", pcTaken, e.pcTaken);
                    checkResultSrc("resultSrc", resultSrc, e.resultSrc);
                    checkRegAddr("rdAddr", rdAddr, e.rdAddr);
                    checkWord("result", result, e.result);
                    checkWord("storeData", storeData, e.storeData);
                    checkWord("pcNext", pcNext, e.pcNext);
                    checked++;
                end
            end else begin
                checkBit("outValid", outValid, 1'b0); // catches x too
                checkBit("regWrite", regWrite, 1'b0);
                checkBit("memWrite", memWrite, 1'b0);
                checkBit("pcTaken", pcTaken, 1'b0);
                if (expQ.size() != 0 && expQ[0].due <= negCount)
                    stopRun("an issued instruction never raised outValid");
            end
        end
    end

    initial begin
        #((NUM_INSTR + 8 + 20) * 40);
        stopRun("watchdog expired before all instructions were checked");
    end

    initial begin
        int          f;
        int          n;
        int          kind;
        logic [31:0] r;
        funct3T      f3;
        void'($urandom(32'had80_1032));
        clk        = 1'b0;
        reset      = 1'b1;
        instrValid = 1'b0;
        instr      = '0;
        pc         = '0;
        rs1Data    = '0;
        rs2Data    = '0;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        idle(3);
        for (f = 0; f < 8; f++)
            repeat (4) issueOp(0, f[2:0], 1'b0, 0);
        repeat (4) issueOp(0, 3'b000, 1'b1, 0); // sub
        repeat (4) issueOp(0, 3'b101, 1'b1, 0); // sra
        idle(1);
        for (f = 0; f < 8; f++)
            repeat (4) issueOp(1, f[2:0], 1'b0, 0);
        repeat (4) issueOp(1, 3'b101, 1'b1, 0); // srai
        idle(1);
        repeat (6) issueOp(2, 3'b010, 1'b0, 0);
        repeat (6) issueOp(3, 3'b010, 1'b0, 0);
        idle(1);
        for (f = 0; f < 8; f++) begin
            if (f != 2 && f != 3) begin // reserved branch codes
                repeat (2) issueOp(4, f[2:0], 1'b0, 1);
                repeat (3) issueOp(4, f[2:0], 1'b0, 0);
                issueOp(4, f[2:0], 1'b0, 2);
            end
        end
        idle(1);
        for (kind = 5; kind < 9; kind++)
            repeat (4) issueOp(kind, 3'b000, 1'b0, 0);
        idle(1);
        for (n = 0; n < NUM_MIX; n++) begin // back to back
            r    = randWord();
            kind = int'(r % 32'd9);
            f3   = r[6:4];
            if (kind == 4 && f3[2:1] == 2'b01)
                f3[1] = 1'b0;
            issueOp(kind, f3, r[12] && (f3 == 3'b101 || (kind == 0 && f3 == 3'b000)),
                    r[13] ? 1 : 0);
        end
        idle(2);
        while (expQ.size() != 0)
            @(negedge clk);
        @(posedge clk);
        if (checked == NUM_INSTR) begin
            $display("TEST OK");
            $finish;
        end else
            stopRun("number of checked results differs from the number of issued instructions");
    end

endmodule
